//--- flist.f
+incdir+test
hdl/lp_filter_pkg.sv
hdl/block_history_ctrl.sv
hdl/fir_lane.sv
hdl/lp_filter_top.sv
test/tb_lp_filter.sv

//--- Makefile
TOP := tb_lp_filter

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f flist.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q '^Simulation PASSED$$'

clean:
	rm -rf obj_dir

//--- test/tb_lp_filter_model.svh
`ifndef TB_LP_FILTER_MODEL_SVH
`define TB_LP_FILTER_MODEL_SVH

////////////////////////////////////////////////////////////
// Random source
////////////////////////////////////////////////////////////

// Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
localparam logic [31:0] LFSR_SEED = 32'h1d25;

logic [31:0] lfsr_q = LFSR_SEED;

// One step per bit taken, newest bit lands in the LSB
function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] val;
    logic fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        val = {val[30:0], fb};
    end
    return val;
endfunction

////////////////////////////////////////////////////////////
// Reference model
////////////////////////////////////////////////////////////

localparam int HIST_LEN = lp_filter_pkg::HIST_BLOCKS * lp_filter_pkg::NUM_LANES;

// Samples of the blocks sent so far, index 0 oldest
int model_hist [HIST_LEN];

// Expected blocks in strobe order
lp_filter_pkg::block_t exp_q [$];
// Set when the block must also sit at the settled DC level
bit dc_q [$];

// Full 33-tap response, even offsets are zero apart from the center
function automatic longint coef_at(input int offs);
    int mirror;
    mirror = offs;
    if (offs > lp_filter_pkg::CENTER_OFFSET) begin
        mirror = 2 * lp_filter_pkg::CENTER_OFFSET - offs;
    end
    if (offs == lp_filter_pkg::CENTER_OFFSET) begin
        return longint'(lp_filter_pkg::COEF_CENTER);
    end
    if (mirror % 2 == 1) begin
        return longint'(lp_filter_pkg::COEF_PAIR[(mirror - 1) / 2]);
    end
    return 0;
endfunction

function automatic void reset_model();
    for (int i = 0; i < HIST_LEN; i++) begin
        model_hist[i] = 0;
    end
endfunction

// Direct convolution over the history plus the new block
function automatic lp_filter_pkg::block_t model_step(input lp_filter_pkg::block_t blk);
    int win [HIST_LEN + lp_filter_pkg::NUM_LANES];
    longint acc;
    lp_filter_pkg::block_t res;
    for (int i = 0; i < HIST_LEN; i++) begin
        win[i] = model_hist[i];
    end
    for (int k = 0; k < lp_filter_pkg::NUM_LANES; k++) begin
        win[HIST_LEN + k] = int'(blk[k]);
    end
    for (int k = 0; k < lp_filter_pkg::NUM_LANES; k++) begin
        acc = 0;
        for (int o = 0; o <= 2 * lp_filter_pkg::CENTER_OFFSET; o++) begin
            acc += coef_at(o) * longint'(win[HIST_LEN + k - o]);
        end
        // Floor of the sum over 2^15, wrapped to the sample width
        acc = acc >>> lp_filter_pkg::OUT_SHIFT;
        res[k] = lp_filter_pkg::sample_t'(acc[lp_filter_pkg::SAMPLE_W-1:0]);
    end
    // Oldest block drops out
    for (int i = 0; i < HIST_LEN; i++) begin
        model_hist[i] = win[i + lp_filter_pkg::NUM_LANES];
    end
    return res;
endfunction

`endif

//--- test/tb_lp_filter.sv
`timescale 1ns/100ps

module tb_lp_filter;

    localparam int CLK_PERIOD = 20;
    localparam int RESET_CYCLES = 4;
    localparam int IDLE_CYCLES = 10;
    localparam int DRAIN_CYCLES = 8;
    localparam int B2B_BLOCKS = 12;
    // Zero blocks that clear the history ahead of the impulse
    localparam int IMPULSE_LEAD = lp_filter_pkg::HIST_BLOCKS;
    localparam int IMPULSE_BLOCKS = 8;
    localparam int IMPULSE_LANE = 3;
    localparam int IMPULSE_LEVEL = 2047;
    localparam int DC_BLOCKS = 8;
    localparam int DC_LEVEL = 1024;
    localparam int DC_SETTLED = 991;
    // First DC block with all 33 taps inside the step
    localparam int DC_SETTLE_BLOCK = 4;
    localparam int RAND_BLOCKS = 40;
    localparam int GAP_BITS = 2;
    localparam int MAX_GAP = 3;
    localparam int PRE_RST_BLOCKS = 10;
    localparam int POST_RST_BLOCKS = 6;

    localparam int STIM_CYCLES = 2 * RESET_CYCLES + IDLE_CYCLES + B2B_BLOCKS
                               + IMPULSE_LEAD + IMPULSE_BLOCKS + DC_BLOCKS
                               + RAND_BLOCKS * (1 + MAX_GAP)
                               + PRE_RST_BLOCKS + POST_RST_BLOCKS + 6 * DRAIN_CYCLES;
    localparam int TIMEOUT_CYCLES = STIM_CYCLES * 3 / 2 + 50;

    logic clk_i = 1'b0;
    logic arst_n_i;
    logic in_valid_i;
    lp_filter_pkg::block_t in_block_i;
    logic out_valid_o;
    lp_filter_pkg::block_t out_block_o;

    int data_errors = 0;
    int timing_errors = 0;
    int early_errors = 0;
    int unexpected_errors = 0;
    int count_errors = 0;
    int in_count = 0;
    int out_count = 0;
    int cycle_cnt = 0;
    bit seen_strobe = 1'b0;

    lp_filter_pkg::block_t exp_blk;
    bit dc_chk;

    `include "tb_lp_filter_model.svh"

    lp_filter_top u_dut (
        .clk_i       (clk_i),
        .arst_n_i    (arst_n_i),
        .in_valid_i  (in_valid_i),
        .in_block_i  (in_block_i),
        .out_valid_o (out_valid_o),
        .out_block_o (out_block_o)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic idle(input int n);
        repeat (n) @(negedge clk_i);
    endtask

    // Starts at a falling edge and ends one falling edge later
    task automatic drive_block(input lp_filter_pkg::block_t blk, input bit dc_settled);
        in_valid_i = 1'b1;
        in_block_i = blk;
        exp_q.push_back(model_step(blk));
        dc_q.push_back(dc_settled);
        in_count++;
        seen_strobe = 1'b1;
        @(negedge clk_i);
        in_valid_i = 1'b0;
    endtask

    function automatic lp_filter_pkg::block_t random_block();
        lp_filter_pkg::block_t blk;
        logic [31:0] r;
        for (int k = 0; k < lp_filter_pkg::NUM_LANES; k++) begin
            r = lfsr_bits(lp_filter_pkg::SAMPLE_W);
            blk[k] = lp_filter_pkg::sample_t'(r[lp_filter_pkg::SAMPLE_W-1:0]);
        end
        return blk;
    endfunction

    // Wait for every block in flight to come out
    task automatic drain();
        while (exp_q.size() != 0) begin
            @(negedge clk_i);
        end
        idle(2);
    endtask

    task automatic report_counts();
        $display("Errors: data %0d, timing %0d, early output %0d, unexpected output %0d, count %0d",
                 data_errors, timing_errors, early_errors, unexpected_errors, count_errors);
    endtask

    ////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        out_valid_o == $past(in_valid_i, 4))
    else begin
        timing_errors++;
        $display("Output strobe at %0t does not match the input strobe 4 cycles earlier", $time);
    end

    assert property (@(posedge clk_i) disable iff (!arst_n_i)
        !seen_strobe |-> !out_valid_o)
    else begin
        early_errors++;
        $display("Output strobe at %0t came before any input block", $time);
    end

    always @(posedge clk_i) begin
        if (arst_n_i && out_valid_o) begin
            out_count++;
            if (exp_q.size() == 0) begin
                unexpected_errors++;
                $display("Output block at %0t arrived while no block was expected", $time);
            end else begin
                exp_blk = exp_q.pop_front();
                dc_chk = dc_q.pop_front();
                for (int k = 0; k < lp_filter_pkg::NUM_LANES; k++) begin
                    assert (out_block_o[k] == exp_blk[k]) else begin
                        data_errors++;
                        $display("Mismatch at %0t: lane %0d got %0d, expected %0d",
                                 $time, k, out_block_o[k], exp_blk[k]);
                    end
                    if (dc_chk) begin
                        assert (out_block_o[k] == lp_filter_pkg::sample_t'(DC_SETTLED)) else begin
                            data_errors++;
                            $display("Mismatch at %0t: lane %0d DC output %0d, settled level %0d",
                                     $time, k, out_block_o[k], DC_SETTLED);
                        end
                    end
                end
            end
        end
    end

    always @(posedge clk_i) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: run still going after %0d cycles", cycle_cnt);
            report_counts();
            $display("Simulation FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        lp_filter_pkg::block_t blk;
        arst_n_i = 1'b0;
        in_valid_i = 1'b0;
        in_block_i = '0;
        reset_model();
        idle(RESET_CYCLES);
        arst_n_i = 1'b1;

        // Quiet period, no output may appear
        idle(IDLE_CYCLES);

        for (int b = 0; b < B2B_BLOCKS; b++) begin
            drive_block(random_block(), 1'b0);
        end
        drain();

        // Zero history, a single impulse, then zero blocks
        for (int b = 0; b < IMPULSE_LEAD + IMPULSE_BLOCKS; b++) begin
            blk = '0;
            if (b == IMPULSE_LEAD) begin
                blk[IMPULSE_LANE] = lp_filter_pkg::sample_t'(IMPULSE_LEVEL);
            end
            drive_block(blk, 1'b0);
        end
        drain();

        // DC step from a zero history
        for (int b = 0; b < DC_BLOCKS; b++) begin
            for (int k = 0; k < lp_filter_pkg::NUM_LANES; k++) begin
                blk[k] = lp_filter_pkg::sample_t'(DC_LEVEL);
            end
            drive_block(blk, b >= DC_SETTLE_BLOCK);
        end
        drain();

        // Random data, random gaps
        for (int b = 0; b < RAND_BLOCKS; b++) begin
            drive_block(random_block(), 1'b0);
            idle(int'(lfsr_bits(GAP_BITS)));
        end
        drain();

        // Fill the history, then reset in the middle of the stream
        for (int b = 0; b < PRE_RST_BLOCKS; b++) begin
            drive_block(random_block(), 1'b0);
        end
        drain();
        arst_n_i = 1'b0;
        idle(RESET_CYCLES);
        arst_n_i = 1'b1;
        reset_model();
        for (int b = 0; b < POST_RST_BLOCKS; b++) begin
            drive_block(random_block(), 1'b0);
        end
        drain();

        if (in_count != out_count || exp_q.size() != 0) begin
            count_errors++;
            $display("Got %0d output blocks for %0d input blocks", out_count, in_count);
        end
        report_counts();
        if (data_errors + timing_errors + early_errors + unexpected_errors + count_errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- hdl/lp_filter_top.sv
`timescale 1ns/100ps

module lp_filter_top (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  logic                  in_valid_i,
    input  lp_filter_pkg::block_t in_block_i,
    output logic                  out_valid_o,
    output lp_filter_pkg::block_t out_block_o
);

    // Shared by every lane
    lp_filter_pkg::window_t window;
    logic [2:0] stage_valid;

    ////////////////////////////////////////////////////////////
    // History and strobes
    ////////////////////////////////////////////////////////////

    block_history_ctrl u_history (
        .clk_i         (clk_i),
        .arst_n_i      (arst_n_i),
        .in_valid_i    (in_valid_i),
        .in_block_i    (in_block_i),
        .window_o      (window),
        .stage_valid_o (stage_valid),
        .out_valid_o   (out_valid_o)
    );

    ////////////////////////////////////////////////////////////
    // Polyphase lanes
    ////////////////////////////////////////////////////////////

    // Lane k filters window sample 32+k
    for (genvar k = 0; k < lp_filter_pkg::NUM_LANES; k++) begin : g_lane
        fir_lane #(
            .LANE (k)
        ) u_lane (
            .clk_i         (clk_i),
            .stage_valid_i (stage_valid),
            .window_i      (window),
            .sample_o      (out_block_o[k])
        );
    end

endmodule

//--- hdl/fir_lane.sv
`timescale 1ns/100ps

module fir_lane #(
    parameter int LANE = 0
) (
    input  logic                   clk_i,
    input  logic [2:0]             stage_valid_i,
    input  lp_filter_pkg::window_t window_i,
    output lp_filter_pkg::sample_t sample_o
);

    // Window index of this lane's newest sample
    localparam int CUR_IDX = lp_filter_pkg::WINDOW_LEN - lp_filter_pkg::NUM_LANES + LANE;

    // Distance between the two ends of the filter
    localparam int SPAN = 2 * lp_filter_pkg::CENTER_OFFSET;

    // Taps selected from the window
    lp_filter_pkg::sample_t near_tap [lp_filter_pkg::NUM_PAIRS];
    lp_filter_pkg::sample_t far_tap [lp_filter_pkg::NUM_PAIRS];
    lp_filter_pkg::sample_t center_tap;

    // Stage 1 results
    lp_filter_pkg::acc_t pair_q [lp_filter_pkg::NUM_PAIRS];
    lp_filter_pkg::acc_t center_q;

    // Stage 2 results
    lp_filter_pkg::acc_t prod_q [lp_filter_pkg::NUM_PAIRS];
    lp_filter_pkg::acc_t center_prod_q;

    // Stage 3
    lp_filter_pkg::acc_t tap_sum;
    lp_filter_pkg::sample_t sample_q;

    ////////////////////////////////////////////////////////////
    // Tap selection
    ////////////////////////////////////////////////////////////

    // Pair p covers offsets 2p+1 and 32-(2p+1)
    for (genvar p = 0; p < lp_filter_pkg::NUM_PAIRS; p++) begin : g_taps
        localparam int OFFS = 2 * p + 1;

        assign near_tap[p] = window_i[CUR_IDX - OFFS];
        assign far_tap[p]  = window_i[CUR_IDX - SPAN + OFFS];
    end

    assign center_tap = window_i[CUR_IDX - lp_filter_pkg::CENTER_OFFSET];

    ////////////////////////////////////////////////////////////
    // Stage 1: symmetric pre-add
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (stage_valid_i[0]) begin
            for (int p = 0; p < lp_filter_pkg::NUM_PAIRS; p++) begin
                // Sign-extend both samples before the add
                pair_q[p] <= lp_filter_pkg::acc_t'(near_tap[p])
                           + lp_filter_pkg::acc_t'(far_tap[p]);
            end
            center_q <= lp_filter_pkg::acc_t'(center_tap);
        end
    end

    ////////////////////////////////////////////////////////////
    // Stage 2: coefficient multiply
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk_i) begin
        if (stage_valid_i[1]) begin
            for (int p = 0; p < lp_filter_pkg::NUM_PAIRS; p++) begin
                prod_q[p] <= pair_q[p] * lp_filter_pkg::acc_t'(lp_filter_pkg::COEF_PAIR[p]);
            end
            center_prod_q <= center_q * lp_filter_pkg::acc_t'(lp_filter_pkg::COEF_CENTER);
        end
    end

    ////////////////////////////////////////////////////////////
    // Stage 3: sum and truncate
    ////////////////////////////////////////////////////////////

    // Nine products, far below the accumulator range
    always_comb begin
        tap_sum = center_prod_q;
        for (int p = 0; p < lp_filter_pkg::NUM_PAIRS; p++) begin
            tap_sum = tap_sum + prod_q[p];
        end
    end

    // Arithmetic shift gives floor rounding
    // Keeping the low bits wraps on overflow
    always_ff @(posedge clk_i) begin
        if (stage_valid_i[2]) begin
            sample_q <= lp_filter_pkg::sample_t'(tap_sum >>> lp_filter_pkg::OUT_SHIFT);
        end
    end

    assign sample_o = sample_q;

endmodule

//--- hdl/block_history_ctrl.sv
`timescale 1ns/100ps

module block_history_ctrl (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic                   in_valid_i,
    input  lp_filter_pkg::block_t  in_block_i,
    output lp_filter_pkg::window_t window_o,
    output logic [2:0]             stage_valid_o,
    output logic                   out_valid_o
);

    // Index 0 holds the oldest kept block
    lp_filter_pkg::block_t [lp_filter_pkg::HIST_BLOCKS-1:0] hist_q;

    // Window seen by all lanes for one block
    lp_filter_pkg::window_t window_q;

    // Input strobe delayed by 1 to 4 cycles
    logic [3:0] valid_q;

    ////////////////////////////////////////////////////////////
    // Block history
    ////////////////////////////////////////////////////////////

    // Advances only on an input strobe so gaps do not age the data
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            hist_q <= '0;
        end else if (in_valid_i) begin
            // Oldest block drops out at index 0
            hist_q <= {in_block_i, hist_q[lp_filter_pkg::HIST_BLOCKS-1:1]};
        end
    end

    ////////////////////////////////////////////////////////////
    // Sample window
    ////////////////////////////////////////////////////////////

    // Old history below, incoming block at the top indices
    always_ff @(posedge clk_i) begin
        if (in_valid_i) begin
            window_q <= {in_block_i, hist_q};
        end
    end

    assign window_o = window_q;

    ////////////////////////////////////////////////////////////
    // Pipeline strobes
    ////////////////////////////////////////////////////////////

    // Bit 0 qualifies the window and lane stage 1
    // Bits 1 and 2 drive lane stages 2 and 3
    // Bit 3 marks the lane outputs as valid
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[2:0], in_valid_i};
        end
    end

    assign stage_valid_o = valid_q[2:0];
    assign out_valid_o   = valid_q[3];

endmodule

//--- hdl/lp_filter_pkg.sv
package lp_filter_pkg;

    ////////////////////////////////////////////////////////////
    // Sizes and widths
    ////////////////////////////////////////////////////////////

    // Samples per block, one per lane
    localparam int NUM_LANES = 8;

    localparam int SAMPLE_W = 12;

    // Previous blocks kept for the tap window
    localparam int HIST_BLOCKS = 4;

    // Kept history plus the current block
    localparam int WINDOW_LEN = (HIST_BLOCKS + 1) * NUM_LANES;

    // Signed Q15 coefficients
    localparam int COEF_W = 18;

    localparam int ACC_W = 36;

    // Removes the Q15 scaling
    localparam int OUT_SHIFT = 15;

    ////////////////////////////////////////////////////////////
    // Half-band coefficients
    ////////////////////////////////////////////////////////////

    // Odd-offset taps fold into symmetric pairs
    localparam int NUM_PAIRS = 8;
    localparam int CENTER_OFFSET = 16;

    // Outer pair first: 1/31, 3/29, 5/27 ... 15/17
    localparam logic signed [COEF_W-1:0] COEF_PAIR [NUM_PAIRS] = '{
        -18'sd23,
        18'sd105,
        -18'sd526,
        18'sd263,
        -18'sd949,
        18'sd1672,
        -18'sd3216,
        18'sd10342
    };

    // One half in Q15
    localparam logic signed [COEF_W-1:0] COEF_CENTER = 18'sd16384;

    ////////////////////////////////////////////////////////////
    // Types
    ////////////////////////////////////////////////////////////

    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // Lane 0 is the oldest sample of the block
    typedef sample_t [NUM_LANES-1:0] block_t;

    // Index 0 is the oldest kept sample, current block on top
    typedef sample_t [WINDOW_LEN-1:0] window_t;

    // Pre-add sums, products and the tap sum
    typedef logic signed [ACC_W-1:0] acc_t;

endpackage
